//--- source/adc_capture_pkg.sv
`default_nettype none

package adc_capture_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data widths
  ////////////////////////////////////////////////////////////////////////////

  // raw converter sample
  localparam int sample_width = 12;

  // one sign-extended lane, byte aligned for the stream
  localparam int lane_width = 16;

  // two channels x two slots x (i, q)
  localparam int word_width = 8 * lane_width;

  // flops per synchronizer chain
  localparam int sync_stages = 2;

  ////////////////////////////////////////////////////////////////////////////
  // handshake states
  ////////////////////////////////////////////////////////////////////////////

  // data_clk side of the four-phase crossing
  typedef enum logic [1:0] {
    snd_idle,
    snd_req_high,
    snd_wait_ack_low
  } sender_state_t;

  // m_axis_clk side of the four-phase crossing
  typedef enum logic [1:0] {
    rcv_idle,
    rcv_deliver,
    rcv_ack_high
  } receiver_state_t;

endpackage

`default_nettype wire

//--- source/iq_frame_packer.sv
`timescale 1ns/1ps
`default_nettype none

module iq_frame_packer
  import adc_capture_pkg::*;
(
  input  wire                    data_clk,
  input  wire                    rst_n,
  input  wire                    valid_0,
  input  wire                    valid_1,
  input  wire                    valid_2,
  input  wire                    valid_3,
  input  wire [sample_width-1:0] data_i0,
  input  wire [sample_width-1:0] data_q0,
  input  wire [sample_width-1:0] data_i1,
  input  wire [sample_width-1:0] data_q1,
  input  wire [sample_width-1:0] data_i2,
  input  wire [sample_width-1:0] data_q2,
  input  wire [sample_width-1:0] data_i3,
  input  wire [sample_width-1:0] data_q3,
  output logic [word_width-1:0]  frame_word,
  output logic                   frame_strobe
);

  logic set_complete;

  // replicate the sample msb into the upper lane bits
  function automatic logic [lane_width-1:0] sign_ext(input logic [sample_width-1:0] s);
    sign_ext = {{(lane_width - sample_width){s[sample_width-1]}}, s};
  endfunction

  // a set counts only when every strobe is up in the same cycle
  assign set_complete = valid_0 & valid_1 & valid_2 & valid_3;

  always_ff @(posedge data_clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_strobe <= 1'b0;
    end else begin
      frame_strobe <= set_complete;
    end
  end

  // lane order from bit 0 up: q3 i3 q2 i2 q1 i1 q0 i0
  always_ff @(posedge data_clk) begin
    if (set_complete) begin
      frame_word <= {
        sign_ext(data_i0),
        sign_ext(data_q0),
        sign_ext(data_i1),
        sign_ext(data_q1),
        sign_ext(data_i2),
        sign_ext(data_q2),
        sign_ext(data_i3),
        sign_ext(data_q3)
      };
    end
  end

endmodule

`default_nettype wire

//--- source/frame_cdc_sender.sv
`timescale 1ns/1ps
`default_nettype none

module frame_cdc_sender
  import adc_capture_pkg::*;
(
  input  wire                   data_clk,
  input  wire                   rst_n,
  input  wire [word_width-1:0]  frame_word,
  input  wire                   frame_strobe,
  input  wire                   xfer_ack,
  output logic [word_width-1:0] xfer_word,
  output logic                  xfer_req,
  output logic                  overrun
);

  sender_state_t          state;
  logic [sync_stages-1:0] ack_sync;
  logic                   ack_seen;

  // ack arrives from the m_axis_clk domain
  always_ff @(posedge data_clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_sync <= '0;
    end else begin
      ack_sync <= {ack_sync[sync_stages-2:0], xfer_ack};
    end
  end

  assign ack_seen = ack_sync[sync_stages-1];

  ////////////////////////////////////////////////////////////////////////////
  // four-phase handshake, data_clk side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge data_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= snd_idle;
      xfer_req <= 1'b0;
      overrun  <= 1'b0;
    end else begin
      // any set arriving outside idle is lost
      if (frame_strobe && state != snd_idle) begin
        overrun <= 1'b1;
      end
      case (state)
        snd_idle: begin
          if (frame_strobe) begin
            xfer_req <= 1'b1;
            state    <= snd_req_high;
          end
        end
        snd_req_high: begin
          if (ack_seen) begin
            xfer_req <= 1'b0;
            state    <= snd_wait_ack_low;
          end
        end
        snd_wait_ack_low: begin
          if (!ack_seen) begin
            state <= snd_idle;
          end
        end
        default: state <= snd_idle;
      endcase
    end
  end

  // held stable for the whole time req is up
  always_ff @(posedge data_clk) begin
    if (frame_strobe && state == snd_idle) begin
      xfer_word <= frame_word;
    end
  end

endmodule

`default_nettype wire

//--- source/frame_cdc_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module frame_cdc_receiver
  import adc_capture_pkg::*;
(
  input  wire                   m_axis_clk,
  input  wire                   rst_n,
  input  wire [word_width-1:0]  xfer_word,
  input  wire                   xfer_req,
  input  wire                   framer_full,
  output logic                  xfer_ack,
  output logic [word_width-1:0] load_word,
  output logic                  load_strobe
);

  receiver_state_t        state;
  logic [sync_stages-1:0] req_sync;
  logic                   req_seen;

  // req arrives from the data_clk domain
  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      req_sync <= '0;
    end else begin
      req_sync <= {req_sync[sync_stages-2:0], xfer_req};
    end
  end

  assign req_seen = req_sync[sync_stages-1];

  // word is quiet once req is seen here
  always_ff @(posedge m_axis_clk) begin
    if (state == rcv_idle && req_seen) begin
      load_word <= xfer_word;
    end
  end

  // hand over only when the output register is free
  assign load_strobe = (state == rcv_deliver) && !framer_full;

  ////////////////////////////////////////////////////////////////////////////
  // four-phase handshake, m_axis_clk side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rcv_idle;
      xfer_ack <= 1'b0;
    end else begin
      case (state)
        rcv_idle: begin
          if (req_seen) begin
            state <= rcv_deliver;
          end
        end
        rcv_deliver: begin
          if (load_strobe) begin
            xfer_ack <= 1'b1;
            state    <= rcv_ack_high;
          end
        end
        rcv_ack_high: begin
          // sender has let go of req
          if (!req_seen) begin
            xfer_ack <= 1'b0;
            state    <= rcv_idle;
          end
        end
        default: state <= rcv_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/axis_burst_framer.sv
`timescale 1ns/1ps
`default_nettype none

module axis_burst_framer
  import adc_capture_pkg::*;
#(
  parameter int axis_burst_length = 512
) (
  input  wire                   m_axis_clk,
  input  wire                   rst_n,
  input  wire [word_width-1:0]  load_word,
  input  wire                   load_strobe,
  input  wire                   m_axis_tready,
  output logic                  m_axis_tvalid,
  output logic [word_width-1:0] m_axis_tdata,
  output logic                  m_axis_tlast,
  output logic                  framer_full
);

  localparam int count_width = (axis_burst_length > 1) ? $clog2(axis_burst_length) : 1;
  localparam logic [count_width-1:0] last_beat = count_width'(axis_burst_length - 1);

  logic [count_width-1:0] beat_count;
  logic                   beat_done;

  assign beat_done   = m_axis_tvalid & m_axis_tready;
  assign framer_full = m_axis_tvalid;

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      m_axis_tvalid <= 1'b0;
      m_axis_tlast  <= 1'b0;
    end else if (load_strobe) begin
      m_axis_tvalid <= 1'b1;
      // count already points at this beat
      m_axis_tlast  <= (beat_count == last_beat);
    end else if (beat_done) begin
      m_axis_tvalid <= 1'b0;
      m_axis_tlast  <= 1'b0;
    end
  end

  always_ff @(posedge m_axis_clk) begin
    if (load_strobe) begin
      m_axis_tdata <= load_word;
    end
  end

  // accepted beats within the current burst
  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_count <= '0;
    end else if (beat_done) begin
      if (beat_count == last_beat) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/ad9361_dual_axis_top.sv
`timescale 1ns/1ps
`default_nettype none

module ad9361_dual_axis_top #(
  parameter int axis_burst_length = 512
) (
  input  wire                                      data_clk,
  input  wire                                      m_axis_clk,
  input  wire                                      rst_n,
  input  wire                                      valid_0,
  input  wire                                      valid_1,
  input  wire                                      valid_2,
  input  wire                                      valid_3,
  input  wire [adc_capture_pkg::sample_width-1:0]  data_i0,
  input  wire [adc_capture_pkg::sample_width-1:0]  data_q0,
  input  wire [adc_capture_pkg::sample_width-1:0]  data_i1,
  input  wire [adc_capture_pkg::sample_width-1:0]  data_q1,
  input  wire [adc_capture_pkg::sample_width-1:0]  data_i2,
  input  wire [adc_capture_pkg::sample_width-1:0]  data_q2,
  input  wire [adc_capture_pkg::sample_width-1:0]  data_i3,
  input  wire [adc_capture_pkg::sample_width-1:0]  data_q3,
  input  wire                                      m_axis_tready,
  output wire                                      m_axis_tvalid,
  output wire                                      m_axis_tlast,
  output wire [adc_capture_pkg::word_width-1:0]    m_axis_tdata,
  output wire                                      overrun
);

  // data_clk domain
  wire [adc_capture_pkg::word_width-1:0] frame_word;
  wire                                   frame_strobe;
  wire [adc_capture_pkg::word_width-1:0] xfer_word;
  wire                                   xfer_req;

  // m_axis_clk domain
  wire                                   xfer_ack;
  wire [adc_capture_pkg::word_width-1:0] load_word;
  wire                                   load_strobe;
  wire                                   framer_full;

  iq_frame_packer iq_frame_packer_i (
    .data_clk     (data_clk),
    .rst_n        (rst_n),
    .valid_0      (valid_0),
    .valid_1      (valid_1),
    .valid_2      (valid_2),
    .valid_3      (valid_3),
    .data_i0      (data_i0),
    .data_q0      (data_q0),
    .data_i1      (data_i1),
    .data_q1      (data_q1),
    .data_i2      (data_i2),
    .data_q2      (data_q2),
    .data_i3      (data_i3),
    .data_q3      (data_q3),
    .frame_word   (frame_word),
    .frame_strobe (frame_strobe)
  );

  frame_cdc_sender frame_cdc_sender_i (
    .data_clk     (data_clk),
    .rst_n        (rst_n),
    .frame_word   (frame_word),
    .frame_strobe (frame_strobe),
    .xfer_ack     (xfer_ack),
    .xfer_word    (xfer_word),
    .xfer_req     (xfer_req),
    .overrun      (overrun)
  );

  frame_cdc_receiver frame_cdc_receiver_i (
    .m_axis_clk   (m_axis_clk),
    .rst_n        (rst_n),
    .xfer_word    (xfer_word),
    .xfer_req     (xfer_req),
    .framer_full  (framer_full),
    .xfer_ack     (xfer_ack),
    .load_word    (load_word),
    .load_strobe  (load_strobe)
  );

  axis_burst_framer #(
    .axis_burst_length (axis_burst_length)
  ) axis_burst_framer_i (
    .m_axis_clk    (m_axis_clk),
    .rst_n         (rst_n),
    .load_word     (load_word),
    .load_strobe   (load_strobe),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .framer_full   (framer_full)
  );

endmodule

`default_nettype wire

//--- tb/ad9361_dual_axis_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ad9361_dual_axis_sva
  import adc_capture_pkg::*;
(
  input wire                  m_axis_clk,
  input wire                  rst_n,
  input wire                  m_axis_tvalid,
  input wire                  m_axis_tready,
  input wire                  m_axis_tlast,
  input wire [word_width-1:0] m_axis_tdata,
  input wire                  xfer_req,
  input wire                  xfer_ack
);

  int assert_failures = 0;

  ////////////////////////////////////////////////////////////////////////////
  // stream side
  ////////////////////////////////////////////////////////////////////////////

  // an offered word stays put until it is taken
  stream_hold_a : assert property (
    @(posedge m_axis_clk) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)
  ) else begin
    $error("tvalid fell or tdata/tlast changed while tready was low");
    assert_failures++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // four-phase crossing
  ////////////////////////////////////////////////////////////////////////////

  req_fall_a : assert property (
    @(posedge m_axis_clk) disable iff (!rst_n)
    $fell(xfer_req) |-> xfer_ack
  ) else begin
    $error("xfer_req fell before xfer_ack had risen");
    assert_failures++;
  end

  ack_rise_a : assert property (
    @(posedge m_axis_clk) disable iff (!rst_n)
    $rose(xfer_ack) |-> xfer_req
  ) else begin
    $error("xfer_ack rose while xfer_req was low");
    assert_failures++;
  end

endmodule

bind ad9361_dual_axis_top ad9361_dual_axis_sva sva_i (
  .m_axis_clk    (m_axis_clk),
  .rst_n         (rst_n),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tlast  (m_axis_tlast),
  .m_axis_tdata  (m_axis_tdata),
  .xfer_req      (xfer_req),
  .xfer_ack      (xfer_ack)
);

`default_nettype wire

//--- tb/ad9361_dual_axis_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ad9361_dual_axis_tb
  import adc_capture_pkg::*;
();

  localparam int burst_length = 4;
  localparam int num_sets     = 14;
  localparam int fields       = 13;
  localparam int data_period  = 10;
  localparam int axis_period  = 4;

  logic                    data_clk;
  logic                    m_axis_clk;
  logic                    rst_n;
  logic                    valid_0;
  logic                    valid_1;
  logic                    valid_2;
  logic                    valid_3;
  logic [sample_width-1:0] data_i0;
  logic [sample_width-1:0] data_q0;
  logic [sample_width-1:0] data_i1;
  logic [sample_width-1:0] data_q1;
  logic [sample_width-1:0] data_i2;
  logic [sample_width-1:0] data_q2;
  logic [sample_width-1:0] data_i3;
  logic [sample_width-1:0] data_q3;
  logic                    m_axis_tready;
  wire                     m_axis_tvalid;
  wire                     m_axis_tlast;
  wire  [word_width-1:0]   m_axis_tdata;
  wire                     overrun;

  // mask, eight samples, word, tlast, deliver and hold for each set
  logic [word_width-1:0] golden_mem [0:num_sets*fields-1];
  // {tlast, tdata} of every word still owed by the DUT
  logic [word_width:0]   expected_q [$];
  logic [31:0]           lfsr = 32'hd7ea;
  logic                  stall;
  logic                  expect_overrun;

  ad9361_dual_axis_top #(
    .axis_burst_length (burst_length)
  ) ad9361_dual_axis_top_i (
    .data_clk      (data_clk),
    .m_axis_clk    (m_axis_clk),
    .rst_n         (rst_n),
    .valid_0       (valid_0),
    .valid_1       (valid_1),
    .valid_2       (valid_2),
    .valid_3       (valid_3),
    .data_i0       (data_i0),
    .data_q0       (data_q0),
    .data_i1       (data_i1),
    .data_q1       (data_q1),
    .data_i2       (data_i2),
    .data_q2       (data_q2),
    .data_i3       (data_i3),
    .data_q3       (data_q3),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tdata  (m_axis_tdata),
    .overrun       (overrun)
  );

  always #(data_period / 2) data_clk = ~data_clk;
  always #(axis_period / 2) m_axis_clk = ~m_axis_clk;

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic check_value(input string name, input logic [word_width-1:0] got,
                             input logic [word_width-1:0] want);
    if (got !== want) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
      $display("Result: FAILED");
      $fatal(1, "check failed on %s", name);
    end
  endtask

  // one set, then idle until 16 data_clk cycles have passed
  task automatic present_set(input int base);
    @(posedge data_clk);
    valid_0 <= golden_mem[base][0];
    valid_1 <= golden_mem[base][1];
    valid_2 <= golden_mem[base][2];
    valid_3 <= golden_mem[base][3];
    data_i0 <= golden_mem[base+1][sample_width-1:0];
    data_q0 <= golden_mem[base+2][sample_width-1:0];
    data_i1 <= golden_mem[base+3][sample_width-1:0];
    data_q1 <= golden_mem[base+4][sample_width-1:0];
    data_i2 <= golden_mem[base+5][sample_width-1:0];
    data_q2 <= golden_mem[base+6][sample_width-1:0];
    data_i3 <= golden_mem[base+7][sample_width-1:0];
    data_q3 <= golden_mem[base+8][sample_width-1:0];
    @(posedge data_clk);
    {valid_3, valid_2, valid_1, valid_0} <= 4'h0;
    repeat (14) @(posedge data_clk);
  endtask

  // release tready and let the crossing settle back to idle
  task automatic drain_stream();
    stall <= 1'b0;
    while (expected_q.size() != 0) @(posedge m_axis_clk);
    repeat (16) @(posedge data_clk);
  endtask

  always @(posedge m_axis_clk) begin
    if (stall) begin
      m_axis_tready <= 1'b0;
    end else begin
      m_axis_tready <= lfsr[0];
      lfsr          <= lfsr_step(lfsr);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge m_axis_clk) begin
    logic [word_width:0] beat;
    if (rst_n && m_axis_tvalid && m_axis_tready) begin
      if (expected_q.size() == 0) begin
        $display("the stream delivered a word that no sample set accounts for");
        $display("Result: FAILED");
        $fatal(1, "unexpected beat");
      end else begin
        beat = expected_q.pop_front();
        check_value("m_axis_tdata", m_axis_tdata, beat[word_width-1:0]);
        check_value("m_axis_tlast", m_axis_tlast, beat[word_width]);
      end
    end
  end

  // a bound assertion fired on the stream or the crossing
  always @(ad9361_dual_axis_top_i.sva_i.assert_failures) begin
    if (ad9361_dual_axis_top_i.sva_i.assert_failures != 0) begin
      $display("a bound assertion on the stream or the crossing failed");
      $display("Result: FAILED");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    #(num_sets * 16 * data_period * 4);
    $display("timeout: the stream did not finish in the expected time");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int   base;
    logic hold;
    data_clk       = 1'b0;
    m_axis_clk     = 1'b0;
    rst_n          = 1'b0;
    {valid_3, valid_2, valid_1, valid_0} = 4'h0;
    {data_i0, data_q0, data_i1, data_q1} = '0;
    {data_i2, data_q2, data_i3, data_q3} = '0;
    m_axis_tready  = 1'b0;
    stall          = 1'b0;
    expect_overrun = 1'b0;
    $readmemh("tb/golden_frames.hex", golden_mem);
    if ($isunknown(golden_mem[num_sets*fields-1])) begin
      $display("the golden file is missing or holds too few sample sets");
      $display("Result: FAILED");
      $fatal(1, "bad golden file");
    end
    repeat (4) @(posedge m_axis_clk);
    rst_n <= 1'b1;
    @(posedge m_axis_clk);
    check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_value("m_axis_tlast", m_axis_tlast, 1'b0);
    check_value("overrun", overrun, 1'b0);

    for (int n = 0; n < num_sets; n++) begin
      base = n * fields;
      hold = golden_mem[base+12][0];
      // stall phase starts from an empty pipeline
      if (hold && !stall) begin
        drain_stream();
        check_value("overrun", overrun, 1'b0);
        stall <= 1'b1;
        @(posedge m_axis_clk);
      end else if (!hold && stall) begin
        drain_stream();
      end
      if (golden_mem[base+11][0]) begin
        expected_q.push_back({golden_mem[base+10][0], golden_mem[base+9]});
      end else if (golden_mem[base][3:0] == 4'hf) begin
        expect_overrun = 1'b1;
      end
      present_set(base);
    end

    drain_stream();
    check_value("overrun", overrun, expect_overrun);
    if (ad9361_dual_axis_top_i.sva_i.assert_failures == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1, "bound assertions failed");
    end
  end

endmodule

`default_nettype wire

//--- tb/golden_frames.hex
// mask i0 q0 i1 q1 i2 q2 i3 q3 | word, i0 lane high down to q3 lane low | tlast deliver hold
// mask bit n drives valid_n; hold keeps tready low while the set is presented
f 001 002 003 004 005 006 007 008 0001_0002_0003_0004_0005_0006_0007_0008 0 1 0
f 800 fff 7ff 123 abc 456 f00 0ff f800_ffff_07ff_0123_fabc_0456_ff00_00ff 0 1 0
7 111 222 333 444 555 666 777 888 0 0 0 0
f 9a5 35a c3c 3c3 e01 1fe 7a0 85f f9a5_035a_fc3c_03c3_fe01_01fe_07a0_f85f 0 1 0
0 abc abc abc abc abc abc abc abc 0 0 0 0
f 010 020 030 040 fd0 fc0 fb0 fa0 0010_0020_0030_0040_ffd0_ffc0_ffb0_ffa0 1 1 0
b 0f0 0f1 0f2 0f3 0f4 0f5 0f6 0f7 0 0 0 0
f 0aa 0bb 0cc 0dd 0ee 0ff 100 211 00aa_00bb_00cc_00dd_00ee_00ff_0100_0211 0 1 0
f 801 802 803 804 805 806 807 808 f801_f802_f803_f804_f805_f806_f807_f808 0 1 1
f 07f 17f 27f 37f 47f 57f 67f 77f 007f_017f_027f_037f_047f_057f_067f_077f 0 1 1
f 555 555 555 555 555 555 555 555 0 0 0 1
f aaa aaa aaa aaa aaa aaa aaa aaa 0 0 0 1
f 321 654 987 cba fed 0ab 1cd 2ef 0321_0654_f987_fcba_ffed_00ab_01cd_02ef 1 1 0
f 000 fff 000 fff 800 7ff 800 7ff 0000_ffff_0000_ffff_f800_07ff_f800_07ff 0 1 0

//--- project.f
source/adc_capture_pkg.sv
source/iq_frame_packer.sv
source/frame_cdc_sender.sv
source/frame_cdc_receiver.sv
source/axis_burst_framer.sv
source/ad9361_dual_axis_top.sv
tb/ad9361_dual_axis_sva.sv
tb/ad9361_dual_axis_tb.sv
